// ==== hdl/vmul_pkg.sv ====
package vmul_pkg;

	localparam int VEC_W  = 64;
	localparam int ADDR_W = 32;

	localparam int N_BYTE = VEC_W / 8;
	localparam int N_HALF = VEC_W / 16;
	localparam int N_WORD = VEC_W / 32;

	// lane operands carry one extra bit, sign or zero
	localparam int BYTE_XW = 9;
	localparam int HALF_XW = 17;
	localparam int WORD_XW = 33;

	localparam int BYTE_PW = 2 * BYTE_XW;
	localparam int HALF_PW = 2 * HALF_XW;
	localparam int WORD_PW = 2 * WORD_XW;

	typedef enum logic [1:0] {
		sew_8  = 2'd0,
		sew_16 = 2'd1,
		sew_32 = 2'd2,
		sew_64 = 2'd3	// reserved
	} sew_e;

	typedef enum logic [1:0] {
		op_mul   = 2'd0,	// low half
		op_mulh  = 2'd1,	// high half, signed x signed
		op_mulhu = 2'd2	// high half, unsigned x unsigned
	} op_e;

	typedef struct packed {
		logic [VEC_W-1:0]  vec0;
		logic [VEC_W-1:0]  vec1;
		sew_e              sew;
		op_e               op;
		logic [ADDR_W-1:0] addr;
	} mul_req_t;

	typedef struct packed {
		logic [VEC_W-1:0]  vec;
		logic [ADDR_W-1:0] addr;
	} mul_resp_t;

	typedef struct packed {
		sew_e              sew;
		logic              high;
		logic [ADDR_W-1:0] addr;
	} stage_ctrl_t;

	typedef struct packed {
		logic [N_BYTE-1:0][BYTE_XW-1:0] a_byte;
		logic [N_BYTE-1:0][BYTE_XW-1:0] b_byte;
		logic [N_HALF-1:0][HALF_XW-1:0] a_half;
		logic [N_HALF-1:0][HALF_XW-1:0] b_half;
		logic [N_WORD-1:0][WORD_XW-1:0] a_word;
		logic [N_WORD-1:0][WORD_XW-1:0] b_word;
	} lane_opnd_t;

	typedef struct packed {
		logic [N_BYTE-1:0][BYTE_PW-1:0] byte_p;
		logic [N_HALF-1:0][HALF_PW-1:0] half_p;
		logic [N_WORD-1:0][WORD_PW-1:0] word_p;
	} lane_prod_t;

endpackage

// ==== hdl/operand_select.sv ====
`timescale 1ns/10ps

module operand_select (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  advance,
	input  vmul_pkg::mul_req_t    req,
	input  logic                  req_valid,
	output vmul_pkg::lane_opnd_t  opnd,
	output vmul_pkg::stage_ctrl_t ctrl,
	output logic                  opnd_valid
);
	import vmul_pkg::*;

	logic       is_signed;
	logic       high;
	lane_opnd_t opnd_d;

	// op decode
	always_comb begin
		is_signed = (req.op == op_mulh);
		high      = (req.op != op_mul);
	end

	// every lane kind extended at once, width picked at the end
	always_comb begin
		for (int i = 0; i < N_BYTE; i++) begin
			opnd_d.a_byte[i] = {is_signed & req.vec0[8*i+7], req.vec0[8*i +: 8]};
			opnd_d.b_byte[i] = {is_signed & req.vec1[8*i+7], req.vec1[8*i +: 8]};
		end
		for (int i = 0; i < N_HALF; i++) begin
			opnd_d.a_half[i] = {is_signed & req.vec0[16*i+15], req.vec0[16*i +: 16]};
			opnd_d.b_half[i] = {is_signed & req.vec1[16*i+15], req.vec1[16*i +: 16]};
		end
		for (int i = 0; i < N_WORD; i++) begin
			opnd_d.a_word[i] = {is_signed & req.vec0[32*i+31], req.vec0[32*i +: 32]};
			opnd_d.b_word[i] = {is_signed & req.vec1[32*i+31], req.vec1[32*i +: 32]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			opnd_valid <= 1'b0;
		end else if (advance) begin
			opnd_valid <= req_valid;	// req_ready is advance
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			opnd      <= opnd_d;
			ctrl.sew  <= req.sew;
			ctrl.high <= high;
			ctrl.addr <= req.addr;
		end
	end

	// no 64-bit elements, no fourth op
	a_legal_req: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> req.sew != sew_64 && req.op inside {op_mul, op_mulh, op_mulhu});

endmodule

// ==== hdl/lane_mult_array.sv ====
`timescale 1ns/10ps

module lane_mult_array (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  advance,
	input  vmul_pkg::lane_opnd_t  opnd,
	input  vmul_pkg::stage_ctrl_t ctrl_in,
	input  logic                  opnd_valid,
	output vmul_pkg::lane_prod_t  prod,
	output vmul_pkg::stage_ctrl_t ctrl_out,
	output logic                  prod_valid
);
	import vmul_pkg::*;

	lane_prod_t prod_d;

	// one signed multiply per lane covers signed and unsigned
	always_comb begin
		for (int i = 0; i < N_BYTE; i++) begin
			prod_d.byte_p[i] = BYTE_PW'(signed'(opnd.a_byte[i]))
				* BYTE_PW'(signed'(opnd.b_byte[i]));
		end
		for (int i = 0; i < N_HALF; i++) begin
			prod_d.half_p[i] = HALF_PW'(signed'(opnd.a_half[i]))
				* HALF_PW'(signed'(opnd.b_half[i]));
		end
		for (int i = 0; i < N_WORD; i++) begin
			prod_d.word_p[i] = WORD_PW'(signed'(opnd.a_word[i]))
				* WORD_PW'(signed'(opnd.b_word[i]));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
		end else if (advance) begin
			prod_valid <= opnd_valid;
		end
	end

	// all widths held to the last stage
	always_ff @(posedge clk) begin
		if (advance) begin
			prod     <= prod_d;
			ctrl_out <= ctrl_in;
		end
	end

endmodule

// ==== hdl/result_select.sv ====
`timescale 1ns/10ps

module result_select (
	input  logic                  clk,
	input  logic                  rst,
	input  vmul_pkg::lane_prod_t  prod,
	input  vmul_pkg::stage_ctrl_t ctrl,
	input  logic                  prod_valid,
	input  logic                  resp_ready,
	output logic                  advance,
	output vmul_pkg::mul_resp_t   resp,
	output logic                  resp_valid
);
	import vmul_pkg::*;

	logic [VEC_W-1:0] vec_d;

	// whole pipeline stalls only on a held response
	assign advance = !resp_valid || resp_ready;

	always_comb begin
		vec_d = '0;
		case (ctrl.sew)
			sew_8: begin
				for (int i = 0; i < N_BYTE; i++) begin
					vec_d[8*i +: 8] = ctrl.high ? prod.byte_p[i][15:8]
						: prod.byte_p[i][7:0];
				end
			end
			sew_16: begin
				for (int i = 0; i < N_HALF; i++) begin
					vec_d[16*i +: 16] = ctrl.high ? prod.half_p[i][31:16]
						: prod.half_p[i][15:0];
				end
			end
			sew_32: begin
				for (int i = 0; i < N_WORD; i++) begin
					vec_d[32*i +: 32] = ctrl.high ? prod.word_p[i][63:32]
						: prod.word_p[i][31:0];
				end
			end
			default: begin
				vec_d = '0;	// sew_64 reserved
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid <= 1'b0;
			resp       <= '0;
		end else if (advance) begin
			resp_valid <= prod_valid;
			resp.vec   <= vec_d;
			resp.addr  <= ctrl.addr;
		end
	end

	// upstream item frozen while the output is stalled
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		prod_valid && !advance |=> prod_valid && $stable(prod) && $stable(ctrl));

endmodule

// ==== hdl/vmul.sv ====
`timescale 1ns/10ps

module vmul (
	input  logic                clk,
	input  logic                rst,
	input  vmul_pkg::mul_req_t  req,
	input  logic                req_valid,
	output logic                req_ready,
	output vmul_pkg::mul_resp_t resp,
	output logic                resp_valid,
	input  logic                resp_ready
);
	import vmul_pkg::*;

	logic        advance;
	lane_opnd_t  opnd;
	stage_ctrl_t s1_ctrl;
	logic        opnd_valid;
	lane_prod_t  prod;
	stage_ctrl_t s2_ctrl;
	logic        prod_valid;

	assign req_ready = advance;

	operand_select i_operand_select (
		.clk        (clk),
		.rst        (rst),
		.advance    (advance),
		.req        (req),
		.req_valid  (req_valid),
		.opnd       (opnd),
		.ctrl       (s1_ctrl),
		.opnd_valid (opnd_valid)
	);

	lane_mult_array i_lane_mult_array (
		.clk        (clk),
		.rst        (rst),
		.advance    (advance),
		.opnd       (opnd),
		.ctrl_in    (s1_ctrl),
		.opnd_valid (opnd_valid),
		.prod       (prod),
		.ctrl_out   (s2_ctrl),
		.prod_valid (prod_valid)
	);

	result_select i_result_select (
		.clk        (clk),
		.rst        (rst),
		.prod       (prod),
		.ctrl       (s2_ctrl),
		.prod_valid (prod_valid),
		.resp_ready (resp_ready),
		.advance    (advance),
		.resp       (resp),
		.resp_valid (resp_valid)
	);

endmodule

// ==== bench/vmul_model.svh ====
`ifndef VMUL_MODEL_SVH
`define VMUL_MODEL_SVH

// responses still owed by the DUT, oldest first
mul_resp_t exp_q[$];

// lane by lane: full product of the lane pair, then the low or the high half
function automatic mul_resp_t model_mul(input mul_req_t r);
	mul_resp_t   want;
	int          lw;
	logic [63:0] mask;
	longint      a;
	longint      b;
	longint      p;
	logic [63:0] p_bits;
	logic [63:0] half;
	want.vec  = '0;
	want.addr = r.addr;
	case (r.sew)
		sew_8:   lw = 8;
		sew_16:  lw = 16;
		default: lw = 32;
	endcase
	mask = (64'd1 << lw) - 64'd1;
	for (int i = 0; i < VEC_W / lw; i++) begin
		a = longint'((r.vec0 >> (i * lw)) & mask);
		b = longint'((r.vec1 >> (i * lw)) & mask);
		if (r.op == op_mulh) begin
			// lane value as two's complement
			if (a[lw-1])
				a = a - (longint'(1) << lw);
			if (b[lw-1])
				b = b - (longint'(1) << lw);
		end
		p      = a * b;	// 2*lw bits always fit in 64
		p_bits = p;
		if (r.op == op_mul)
			half = p_bits;
		else
			half = p_bits >> lw;
		want.vec = want.vec | ((half & mask) << (i * lw));
	end
	return want;
endfunction

`endif

// ==== bench/vmul_tb.sv ====
`timescale 1ns/10ps

module vmul_tb;
	import vmul_pkg::*;

	localparam int     PERIOD      = 100;
	localparam int     DRV_DLY     = 1;
	localparam int     N_BURST     = 18;
	localparam int     N_RAND      = 2000 - N_BURST;
	localparam int     N_REQ       = N_RAND + N_BURST;
	localparam int     STALL_PCT   = 30;	// resp_ready low
	localparam int     VALID_PCT   = 70;
	localparam longint WATCHDOG_NS = longint'(N_REQ * 8 + 50) * PERIOD;

	logic      clk;
	logic      rst;
	mul_req_t  req;
	logic      req_valid;
	logic      req_ready;
	mul_resp_t resp;
	logic      resp_valid;
	logic      resp_ready;

	int        seed = 32'h492f;
	int        cyc = 0;
	int        n_acc = 0;
	int        acc_q[$];	// accept edge per item, -1 outside the burst
	logic      req_fire = 1'b0;
	logic      in_burst = 1'b0;
	logic      held = 1'b0;
	mul_resp_t held_resp;

	`include "vmul_model.svh"

	vmul i_dut (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.resp       (resp),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	function automatic bit chance(input int pct);
		return ({$random(seed)} % 100) < pct;
	endfunction

	function automatic mul_req_t random_req();
		mul_req_t   r;
		logic [1:0] pick;
		r.vec0 = {$random(seed), $random(seed)};
		r.vec1 = {$random(seed), $random(seed)};
		pick   = 2'({$random(seed)} % 3);
		r.sew  = sew_e'(pick);
		pick   = 2'({$random(seed)} % 3);
		r.op   = op_e'(pick);
		r.addr = $random(seed);
		return r;
	endfunction

	// sampled mid cycle, handshake lands on the next rising edge
	always @(negedge clk) begin : monitor
		mul_resp_t want;
		int        acc;
		if (rst) begin
			req_fire = 1'b0;
			held     = 1'b0;
		end else begin
			req_fire = req_valid && req_ready;
			if (req_fire) begin
				exp_q.push_back(model_mul(req));
				acc_q.push_back(in_burst ? cyc + 1 : -1);
			end
			if (held) begin
				assert (resp_valid && resp == held_resp) else
					stop_run($sformatf("error at %0t ns: held resp changed to %h, was %h",
						$time, resp, held_resp));
			end
			if (resp_valid && resp_ready) begin
				assert (exp_q.size() > 0) else
					stop_run("a response came out with no request outstanding");
				want = exp_q.pop_front();
				acc  = acc_q.pop_front();
				assert (resp.vec == want.vec) else
					stop_run($sformatf("error at %0t ns: vec %h, expected %h (addr %h)",
						$time, resp.vec, want.vec, want.addr));
				assert (resp.addr == want.addr) else
					stop_run($sformatf("error at %0t ns: addr %h, expected %h",
						$time, resp.addr, want.addr));
				if (acc >= 0) begin
					assert (cyc + 1 - acc == 3) else
						stop_run($sformatf("error at %0t ns: latency %0d cycles, expected 3",
							$time, cyc + 1 - acc));
				end
			end
			held      = resp_valid && !resp_ready;
			held_resp = resp;
		end
	end

	task automatic run_random(input int count);
		int issued;
		issued = 0;
		while (n_acc < count) begin
			@(posedge clk);
			#DRV_DLY;
			if (req_fire) begin
				n_acc++;
				req_valid = 1'b0;
			end
			if (!req_valid && issued < count && chance(VALID_PCT)) begin
				req       = random_req();
				req_valid = 1'b1;
				issued++;
			end
			resp_ready = !chance(STALL_PCT);
		end
	endtask

	task automatic drain();
		resp_ready = 1'b1;
		while (exp_q.size() > 0) begin
			@(posedge clk);
			#DRV_DLY;
		end
	endtask

	// back to back, every width and op in turn
	task automatic run_burst(input int count);
		mul_req_t r;
		in_burst   = 1'b1;
		resp_ready = 1'b1;
		for (int i = 0; i < count; i++) begin
			r         = random_req();
			r.sew     = sew_e'(2'(i % 3));
			r.op      = op_e'(2'((i / 3) % 3));
			req       = r;
			req_valid = 1'b1;
			@(posedge clk);
			#DRV_DLY;
			assert (req_fire) else
				stop_run("req_ready dropped in a burst with resp_ready held high");
			n_acc++;
		end
		req_valid = 1'b0;
		in_burst  = 1'b0;
	endtask

	initial begin
		rst        = 1'b1;
		req        = '0;
		req_valid  = 1'b0;
		resp_ready = 1'b0;
		repeat (2) @(posedge clk);
		#DRV_DLY;
		rst = 1'b0;
		assert (!resp_valid && req_ready && resp == '0) else
			stop_run($sformatf("error at %0t ns: bad state after reset", $time));
		run_random(N_RAND);
		drain();
		run_burst(N_BURST);
		drain();
		repeat (5) @(posedge clk);	// room for a stray response
		$display("Test OK");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish in the time allowed");
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== list.f ====
+incdir+bench
hdl/vmul_pkg.sv
hdl/operand_select.sv
hdl/lane_mult_array.sv
hdl/result_select.sv
hdl/vmul.sv
bench/vmul_tb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = vmul_tb
FLIST      = list.f

BUILD = obj_dir
BIN   = $(BUILD)/V$(TOP)
LOG   = sim.log
SRCS  = $(wildcard hdl/*.sv bench/*.sv bench/*.svh)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
